//--- rtl/rvc_pkg.sv
// shared types and encodings for the rv32c expander; referenced by scoped name from every rtl file
`default_nettype none

package rvc_pkg;

  // field widths
  localparam int unsigned FETCH_W = 32;
  localparam int unsigned HALF_W  = 16;
  localparam int unsigned INSTR_W = 32;

  typedef logic [FETCH_W-1:0] fetch_word_t;
  typedef logic [HALF_W-1:0]  rvc_half_t;
  typedef logic [INSTR_W-1:0] rv32_instr_t;

  //////////////////////////////////////////////////////////////////////
  // rv32i major opcodes
  //////////////////////////////////////////////////////////////////////
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  // fixed register numbers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // 3-bit compressed register field maps onto x8..x15
  localparam logic [1:0] CREG_PREFIX = 2'b01;

  // ebreak, imm=1 under the system opcode
  localparam rv32_instr_t INSTR_EBREAK = {12'h001, REG_ZERO, 3'b000, REG_ZERO, OPCODE_SYSTEM};

  //////////////////////////////////////////////////////////////////////
  // result structs
  //////////////////////////////////////////////////////////////////////

  // one quadrant decoder's answer
  typedef struct packed {
    rv32_instr_t instr;
    logic        illegal;
  } quad_result_t;

  // output channel payload
  typedef struct packed {
    rv32_instr_t instr;
    logic        compressed;
    logic        illegal;
  } expand_result_t;

endpackage

`default_nettype wire

//--- rtl/rvc_quadrant0_expander.sv
// combinational expander for quadrant-0 compressed encodings, used by the top-level expander
`timescale 1ns/1ps
`default_nettype none

module rvc_quadrant0_expander (
  input  rvc_pkg::rvc_half_t    c_instr_i,
  output rvc_pkg::quad_result_t result_o
);

  // rd'/rs2' in bits 4:2, rs1' in bits 9:7
  logic [4:0] reg_42;
  logic [4:0] reg_97;

  assign reg_42 = {rvc_pkg::CREG_PREFIX, c_instr_i[4:2]};
  assign reg_97 = {rvc_pkg::CREG_PREFIX, c_instr_i[9:7]};

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (c_instr_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', sp, nzuimm
        // nzuimm[5:4|9:6|2|3] sits in bits 12:5
        result_o.instr = {2'b00, c_instr_i[10:7], c_instr_i[12:11], c_instr_i[5],
                          c_instr_i[6], 2'b00, rvc_pkg::REG_SP, 3'b000, reg_42,
                          rvc_pkg::OPCODE_OPIMM};
        // zero immediate is reserved, covers the all-zero half too
        if (c_instr_i[12:5] == 8'd0) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b010: begin
        // c.lw -> lw rd', uimm(rs1')
        result_o.instr = {5'd0, c_instr_i[5], c_instr_i[12:10], c_instr_i[6], 2'b00,
                          reg_97, 3'b010, reg_42, rvc_pkg::OPCODE_LOAD};
      end

      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1')
        // offset split across the s-type imm fields
        result_o.instr = {5'd0, c_instr_i[5], c_instr_i[12], reg_42, reg_97, 3'b010,
                          c_instr_i[11:10], c_instr_i[6], 2'b00, rvc_pkg::OPCODE_STORE};
      end

      default: begin
        // c.fld/c.flw/c.fsd/c.fsw and the reserved slot
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rvc_quadrant1_expander.sv
// combinational expander for quadrant-1 arithmetic, jump and branch encodings
`timescale 1ns/1ps
`default_nettype none

module rvc_quadrant1_expander (
  input  rvc_pkg::rvc_half_t    c_instr_i,
  output rvc_pkg::quad_result_t result_o
);

  // full rd/rs1 field and the compressed rd'/rs1' and rs2' fields
  logic [4:0]  reg_full;
  logic [4:0]  reg_97;
  logic [4:0]  reg_42;
  // sign-extended 6-bit immediate, shared by addi/li/andi
  logic [11:0] imm6_sext;
  logic [4:0]  link_reg;

  assign reg_full  = c_instr_i[11:7];
  assign reg_97    = {rvc_pkg::CREG_PREFIX, c_instr_i[9:7]};
  assign reg_42    = {rvc_pkg::CREG_PREFIX, c_instr_i[4:2]};
  assign imm6_sext = {{6{c_instr_i[12]}}, c_instr_i[12], c_instr_i[6:2]};
  // c.jal links through ra, c.j discards the link
  assign link_reg  = c_instr_i[15] ? rvc_pkg::REG_ZERO : rvc_pkg::REG_RA;

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (c_instr_i[15:13])
      3'b000: begin
        // c.addi / c.nop -> addi rd, rd, imm
        result_o.instr = {imm6_sext, reg_full, 3'b000, reg_full, rvc_pkg::OPCODE_OPIMM};
      end

      3'b001, 3'b101: begin
        // c.jal / c.j -> jal link, offset
        // j-type order imm[20|10:1|11|19:12]
        result_o.instr = {c_instr_i[12], c_instr_i[8], c_instr_i[10:9], c_instr_i[6],
                          c_instr_i[7], c_instr_i[2], c_instr_i[11], c_instr_i[5:3],
                          {9{c_instr_i[12]}}, link_reg, rvc_pkg::OPCODE_JAL};
      end

      3'b010: begin
        // c.li -> addi rd, x0, imm
        result_o.instr = {imm6_sext, rvc_pkg::REG_ZERO, 3'b000, reg_full,
                          rvc_pkg::OPCODE_OPIMM};
      end

      3'b011: begin
        if (reg_full == rvc_pkg::REG_SP) begin
          // c.addi16sp -> addi sp, sp, nzimm
          // nzimm[9|4|6|8:7|5] in bits 12,6:2
          result_o.instr = {{3{c_instr_i[12]}}, c_instr_i[4:3], c_instr_i[5], c_instr_i[2],
                            c_instr_i[6], 4'b0000, rvc_pkg::REG_SP, 3'b000,
                            rvc_pkg::REG_SP, rvc_pkg::OPCODE_OPIMM};
        end else begin
          // c.lui -> lui rd, nzimm
          result_o.instr = {{15{c_instr_i[12]}}, c_instr_i[6:2], reg_full,
                            rvc_pkg::OPCODE_LUI};
        end
        // reserved for both forms
        if ({c_instr_i[12], c_instr_i[6:2]} == 6'd0) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b100: begin
        unique case (c_instr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 selects arithmetic via funct7[5]
            result_o.instr = {1'b0, c_instr_i[10], 5'd0, c_instr_i[6:2], reg_97, 3'b101,
                              reg_97, rvc_pkg::OPCODE_OPIMM};
            // shamt[5] set is rv32 reserved
            if (c_instr_i[12]) begin
              result_o.illegal = 1'b1;
            end
          end

          2'b10: begin
            // c.andi -> andi rd', rd', imm
            result_o.instr = {imm6_sext, reg_97, 3'b111, reg_97, rvc_pkg::OPCODE_OPIMM};
          end

          default: begin
            // register-register ops on rd'/rs2'
            unique case ({c_instr_i[12], c_instr_i[6:5]})
              3'b000: begin
                result_o.instr = {7'b0100000, reg_42, reg_97, 3'b000, reg_97,
                                  rvc_pkg::OPCODE_OP};
              end
              3'b001: begin
                result_o.instr = {7'd0, reg_42, reg_97, 3'b100, reg_97, rvc_pkg::OPCODE_OP};
              end
              3'b010: begin
                result_o.instr = {7'd0, reg_42, reg_97, 3'b110, reg_97, rvc_pkg::OPCODE_OP};
              end
              3'b011: begin
                result_o.instr = {7'd0, reg_42, reg_97, 3'b111, reg_97, rvc_pkg::OPCODE_OP};
              end
              default: begin
                // subw/addw and unused sub-codes
                result_o.illegal = 1'b1;
              end
            endcase
          end
        endcase
      end

      default: begin
        // c.beqz / c.bnez -> beq/bne rs1', x0, offset
        // bit 13 turns beq into bne
        result_o.instr = {{4{c_instr_i[12]}}, c_instr_i[6:5], c_instr_i[2],
                          rvc_pkg::REG_ZERO, reg_97, 2'b00, c_instr_i[13],
                          c_instr_i[11:10], c_instr_i[4:3], c_instr_i[12],
                          rvc_pkg::OPCODE_BRANCH};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rvc_quadrant2_expander.sv
// combinational expander for quadrant-2 stack, register-move and jump encodings
`timescale 1ns/1ps
`default_nettype none

module rvc_quadrant2_expander (
  input  rvc_pkg::rvc_half_t    c_instr_i,
  output rvc_pkg::quad_result_t result_o
);

  // rd/rs1 in bits 11:7, rs2 in bits 6:2
  logic [4:0] reg_rd;
  logic [4:0] reg_rs2;

  assign reg_rd  = c_instr_i[11:7];
  assign reg_rs2 = c_instr_i[6:2];

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (c_instr_i[15:13])
      3'b000: begin
        // c.slli -> slli rd, rd, shamt
        result_o.instr = {7'd0, reg_rs2, reg_rd, 3'b001, reg_rd, rvc_pkg::OPCODE_OPIMM};
        // shamt[5] not allowed on rv32
        if (c_instr_i[12]) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b010: begin
        // c.lwsp -> lw rd, uimm(sp)
        // uimm[5|4:2|7:6]
        result_o.instr = {4'd0, c_instr_i[3:2], c_instr_i[12], c_instr_i[6:4], 2'b00,
                          rvc_pkg::REG_SP, 3'b010, reg_rd, rvc_pkg::OPCODE_LOAD};
        if (reg_rd == rvc_pkg::REG_ZERO) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b110: begin
        // c.swsp -> sw rs2, uimm(sp)
        result_o.instr = {4'd0, c_instr_i[8:7], c_instr_i[12], reg_rs2, rvc_pkg::REG_SP,
                          3'b010, c_instr_i[11:9], 2'b00, rvc_pkg::OPCODE_STORE};
      end

      3'b100: begin
        if (!c_instr_i[12]) begin
          if (reg_rs2 == rvc_pkg::REG_ZERO) begin
            // c.jr -> jalr x0, 0(rs1)
            result_o.instr = {12'd0, reg_rd, 3'b000, rvc_pkg::REG_ZERO,
                              rvc_pkg::OPCODE_JALR};
            // jr through x0 is reserved
            if (reg_rd == rvc_pkg::REG_ZERO) begin
              result_o.illegal = 1'b1;
            end
          end else begin
            // c.mv -> add rd, x0, rs2
            result_o.instr = {7'd0, reg_rs2, rvc_pkg::REG_ZERO, 3'b000, reg_rd,
                              rvc_pkg::OPCODE_OP};
          end
        end else begin
          if (reg_rs2 == rvc_pkg::REG_ZERO) begin
            if (reg_rd == rvc_pkg::REG_ZERO) begin
              result_o.instr = rvc_pkg::INSTR_EBREAK;
            end else begin
              // c.jalr -> jalr ra, 0(rs1)
              result_o.instr = {12'd0, reg_rd, 3'b000, rvc_pkg::REG_RA,
                                rvc_pkg::OPCODE_JALR};
            end
          end else begin
            // c.add -> add rd, rd, rs2
            result_o.instr = {7'd0, reg_rs2, reg_rd, 3'b000, reg_rd, rvc_pkg::OPCODE_OP};
          end
        end
      end

      default: begin
        // float stack forms and slots taken by dropped extensions
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rvc_expander.sv
// top level of the rv32c expander: quadrant select plus a one-entry valid/ready output stage
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
  input  logic                    clk,
  input  logic                    reset_i,
  // fetch word in
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  rvc_pkg::fetch_word_t    in_word_i,
  // expanded result out
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output rvc_pkg::expand_result_t out_result_o
);

  rvc_pkg::rvc_half_t      c_half;
  rvc_pkg::quad_result_t   q0_res;
  rvc_pkg::quad_result_t   q1_res;
  rvc_pkg::quad_result_t   q2_res;
  rvc_pkg::quad_result_t   q_sel;
  rvc_pkg::expand_result_t exp_res;
  logic                    take_in;

  //////////////////////////////////////////////////////////////////////
  // decode, all three quadrants in parallel
  //////////////////////////////////////////////////////////////////////

  assign c_half = in_word_i[15:0];

  rvc_quadrant0_expander q0_i (
    .c_instr_i (c_half),
    .result_o  (q0_res)
  );

  rvc_quadrant1_expander q1_i (
    .c_instr_i (c_half),
    .result_o  (q1_res)
  );

  rvc_quadrant2_expander q2_i (
    .c_instr_i (c_half),
    .result_o  (q2_res)
  );

  // pick by the quadrant bits
  always_comb begin
    unique case (in_word_i[1:0])
      2'b00: q_sel = q0_res;
      2'b01: q_sel = q1_res;
      2'b10: q_sel = q2_res;
      default: begin
        // full-width instruction passes untouched
        q_sel.instr   = in_word_i;
        q_sel.illegal = 1'b0;
      end
    endcase
  end

  // illegal encodings leave as an all-zero word
  assign exp_res.instr      = q_sel.illegal ? '0 : q_sel.instr;
  assign exp_res.compressed = (in_word_i[1:0] != 2'b11);
  assign exp_res.illegal    = q_sel.illegal;

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  // accept when empty or when the current entry drains this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign take_in    = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk) begin
    if (take_in) begin
      out_result_o <= exp_res;
    end
  end

endmodule

`default_nettype wire

//--- verification/rvc_expander_checker.sv
// concurrent assertions on the expander output channel, attached to rvc_expander by bind
`timescale 1ns/1ps
`default_nettype none

module rvc_expander_checker (
  input logic                    clk,
  input logic                    reset_i,
  input logic                    out_valid_o,
  input logic                    out_ready_i,
  input rvc_pkg::expand_result_t out_result_o
);

  //////////////////////////////////////////////////////////////////////
  // output handshake
  //////////////////////////////////////////////////////////////////////

  // a stalled entry stays put until taken
  assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o))
    else $error("output entry changed while stalled");

  // stage empty on the cycle after any reset edge
  assert property (@(posedge clk) reset_i |=> !out_valid_o)
    else $error("out_valid_o high after reset");

  // only compressed words can be illegal
  assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o |-> (out_result_o.compressed || !out_result_o.illegal))
    else $error("illegal flag set on an uncompressed word");

endmodule

bind rvc_expander rvc_expander_checker checker_i (
  .clk          (clk),
  .reset_i      (reset_i),
  .out_valid_o  (out_valid_o),
  .out_ready_i  (out_ready_i),
  .out_result_o (out_result_o)
);

`default_nettype wire

//--- include/rvc_tb_model.svh
// reference expansion functions for the testbench; include inside the testbench module
`ifndef RVC_TB_MODEL_SVH
`define RVC_TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// format builders
//////////////////////////////////////////////////////////////////////

// sign-extend the low bits of v
function automatic int sext(int v, int bits);
  int s;
  s = v << (32 - bits);
  return s >>> (32 - bits);
endfunction

function automatic rvc_pkg::rv32_instr_t enc_i(int imm, logic [4:0] rs1, logic [2:0] f3,
                                               logic [4:0] rd, logic [6:0] op);
  return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic rvc_pkg::rv32_instr_t enc_r(logic [6:0] f7, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3,
                                               logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rvc_pkg::OPCODE_OP};
endfunction

function automatic rvc_pkg::rv32_instr_t enc_s(int imm, logic [4:0] rs2, logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvc_pkg::OPCODE_STORE};
endfunction

function automatic rvc_pkg::rv32_instr_t enc_b(int imm, logic [4:0] rs1, logic [2:0] f3);
  return {imm[12], imm[10:5], rvc_pkg::REG_ZERO, rs1, f3, imm[4:1], imm[11],
          rvc_pkg::OPCODE_BRANCH};
endfunction

// imm is the upper 20 bits
function automatic rvc_pkg::rv32_instr_t enc_u(int imm, logic [4:0] rd);
  return {imm[19:0], rd, rvc_pkg::OPCODE_LUI};
endfunction

function automatic rvc_pkg::rv32_instr_t enc_j(int imm, logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvc_pkg::OPCODE_JAL};
endfunction

//////////////////////////////////////////////////////////////////////
// expected result for one fetch word
//////////////////////////////////////////////////////////////////////

function automatic rvc_pkg::expand_result_t model_expand(rvc_pkg::fetch_word_t w);
  rvc_pkg::expand_result_t r;
  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  r97;
  logic [4:0]  r42;
  int          imm;
  int          imm6;
  c    = w[15:0];
  rd   = c[11:7];
  rs2  = c[6:2];
  r97  = 5'd8 + c[9:7];
  r42  = 5'd8 + c[4:2];
  imm6 = sext((c[12] << 5) | c[6:2], 6);
  r.instr      = w;
  r.compressed = (w[1:0] != 2'b11);
  r.illegal    = 1'b0;
  if (!r.compressed) begin
    return r;
  end
  case ({c[1:0], c[15:13]})
    // quadrant 0
    5'b00_000: begin
      imm = (c[10:7] << 6) | (c[12:11] << 4) | (c[5] << 3) | (c[6] << 2);
      r.illegal = (imm == 0);
      r.instr   = enc_i(imm, rvc_pkg::REG_SP, 3'b000, r42, rvc_pkg::OPCODE_OPIMM);
    end
    5'b00_010: begin
      imm = (c[5] << 6) | (c[12:10] << 3) | (c[6] << 2);
      r.instr = enc_i(imm, r97, 3'b010, r42, rvc_pkg::OPCODE_LOAD);
    end
    5'b00_110: begin
      imm = (c[5] << 6) | (c[12:10] << 3) | (c[6] << 2);
      r.instr = enc_s(imm, r42, r97);
    end
    // quadrant 1
    5'b01_000: r.instr = enc_i(imm6, rd, 3'b000, rd, rvc_pkg::OPCODE_OPIMM);
    5'b01_001, 5'b01_101: begin
      imm = sext((c[12] << 11) | (c[8] << 10) | (c[10:9] << 8) | (c[6] << 7) | (c[7] << 6) |
                 (c[2] << 5) | (c[11] << 4) | (c[5:3] << 1), 12);
      r.instr = enc_j(imm, c[15] ? 5'd0 : 5'd1);
    end
    5'b01_010: r.instr = enc_i(imm6, 5'd0, 3'b000, rd, rvc_pkg::OPCODE_OPIMM);
    5'b01_011: begin
      r.illegal = (imm6 == 0);
      if (rd == 5'd2) begin
        imm = sext((c[12] << 9) | (c[4:3] << 7) | (c[5] << 6) | (c[2] << 5) | (c[6] << 4), 10);
        r.instr = enc_i(imm, 5'd2, 3'b000, 5'd2, rvc_pkg::OPCODE_OPIMM);
      end else begin
        r.instr = enc_u(imm6, rd);
      end
    end
    5'b01_100: begin
      if (c[11:10] == 2'b10) begin
        r.instr = enc_i(imm6, r97, 3'b111, r97, rvc_pkg::OPCODE_OPIMM);
      end else if (c[11] == 1'b0) begin
        r.illegal = c[12];
        r.instr   = enc_i((c[10] << 10) | c[6:2], r97, 3'b101, r97, rvc_pkg::OPCODE_OPIMM);
      end else begin
        case ({c[12], c[6:5]})
          3'b000: r.instr = enc_r(7'h20, r42, r97, 3'b000, r97);
          3'b001: r.instr = enc_r(7'h00, r42, r97, 3'b100, r97);
          3'b010: r.instr = enc_r(7'h00, r42, r97, 3'b110, r97);
          3'b011: r.instr = enc_r(7'h00, r42, r97, 3'b111, r97);
          default: r.illegal = 1'b1;
        endcase
      end
    end
    5'b01_110, 5'b01_111: begin
      imm = sext((c[12] << 8) | (c[6:5] << 6) | (c[2] << 5) | (c[11:10] << 3) |
                 (c[4:3] << 1), 9);
      r.instr = enc_b(imm, r97, {2'b00, c[13]});
    end
    // quadrant 2
    5'b10_000: begin
      r.illegal = c[12];
      r.instr   = enc_i(rs2, rd, 3'b001, rd, rvc_pkg::OPCODE_OPIMM);
    end
    5'b10_010: begin
      imm = (c[3:2] << 6) | (c[12] << 5) | (c[6:4] << 2);
      r.illegal = (rd == 5'd0);
      r.instr   = enc_i(imm, rvc_pkg::REG_SP, 3'b010, rd, rvc_pkg::OPCODE_LOAD);
    end
    5'b10_110: begin
      imm = (c[8:7] << 6) | (c[12:9] << 2);
      r.instr = enc_s(imm, rs2, rvc_pkg::REG_SP);
    end
    5'b10_100: begin
      if (rs2 != 5'd0) begin
        r.instr = enc_r(7'h00, rs2, c[12] ? rd : 5'd0, 3'b000, rd);
      end else if (c[12] && rd == 5'd0) begin
        r.instr = rvc_pkg::INSTR_EBREAK;
      end else begin
        r.illegal = !c[12] && (rd == 5'd0);
        r.instr   = enc_i(0, rd, 3'b000, {4'd0, c[12]}, rvc_pkg::OPCODE_JALR);
      end
    end
    default: r.illegal = 1'b1;
  endcase
  if (r.illegal) begin
    r.instr = '0;
  end
  return r;
endfunction

`endif

//--- verification/rvc_expander_tb.sv
// testbench for the rv32c expander: random fetch words, back-pressure and a queue-based scoreboard
`timescale 1ns/1ps
`default_nettype none

module rvc_expander_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY  = 1;
  localparam int NUM_ITEMS    = 4000;
  // first words run with out_ready_i held high
  localparam int STEADY_ITEMS = 300;
  localparam int TIMEOUT_NS   = 20 * NUM_ITEMS * CLK_PERIOD;

  logic                    clk = 1'b0;
  logic                    reset_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  rvc_pkg::fetch_word_t    in_word_i;
  logic                    out_valid_o;
  logic                    out_ready_i;
  rvc_pkg::expand_result_t out_result_o;

  int                      seed;
  int                      accepted;
  int                      received;
  // set at the falling edge when the coming rising edge takes the input word
  logic                    in_taken;
  // expected out_valid_o after the last rising edge
  logic                    model_valid;
  rvc_pkg::fetch_word_t    in_flight[$];

  `include "rvc_tb_model.svh"

  rvc_expander dut_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_word_i    (in_word_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_result_o (out_result_o)
  );

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    int unsigned r;
    r = {$random(seed)};
    return r % n;
  endfunction

  // mix of full words, random halves and halves aimed at each reserved form
  function automatic rvc_pkg::fetch_word_t make_word();
    rvc_pkg::fetch_word_t w;
    int unsigned          kind;
    w    = $random(seed);
    kind = rand_below(16);
    if (kind < 2) begin
      w[1:0] = 2'b11;
    end else if (kind >= 5 && kind < 8) begin
      w[1:0] = 2'(rand_below(3));
    end else if (kind >= 8) begin
      case (rand_below(10))
        0: w[15:0] = '0;
        1: begin
          // addi4spn, zero immediate
          w[1:0]   = 2'b00;
          w[15:13] = 3'b000;
          w[12:5]  = '0;
        end
        2: begin
          // lui or addi16sp, zero immediate
          w[1:0]   = 2'b01;
          w[15:13] = 3'b011;
          w[12]    = 1'b0;
          w[6:2]   = '0;
        end
        3: begin
          w[1:0]   = 2'b01;
          w[15:13] = 3'b011;
          w[11:7]  = rvc_pkg::REG_SP;
        end
        4: begin
          // srli/srai, bit 12 random
          w[1:0]   = 2'b01;
          w[15:13] = 3'b100;
          w[11]    = 1'b0;
        end
        5: begin
          w[1:0]   = 2'b10;
          w[15:13] = 3'b000;
        end
        6: begin
          // lwsp to x0
          w[1:0]   = 2'b10;
          w[15:13] = 3'b010;
          w[11:7]  = '0;
        end
        7: begin
          // jr/jalr/ebreak, often through x0
          w[1:0]   = 2'b10;
          w[15:13] = 3'b100;
          w[6:2]   = '0;
          if (rand_below(2) == 0) begin
            w[11:7] = '0;
          end
        end
        8: begin
          // odd funct3 slots of quadrants 0 and 2, float forms included
          w[1:0] = (rand_below(2) == 0) ? 2'b00 : 2'b10;
          w[13]  = 1'b1;
        end
        default: begin
          // register-register group, subw/addw when bit 12 is set
          w[1:0]   = 2'b01;
          w[15:13] = 3'b100;
          w[11:10] = 2'b11;
        end
      endcase
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    seed        = 30;
    reset_i     = 1'b1;
    in_valid_i  = 1'b0;
    in_word_i   = '0;
    out_ready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    while (received < NUM_ITEMS) begin
      // a word that was not taken stays on the bus unchanged
      if (!in_valid_i || in_taken) begin
        if (accepted < NUM_ITEMS && (accepted < STEADY_ITEMS || rand_below(8) != 0)) begin
          in_valid_i = 1'b1;
          in_word_i  = make_word();
        end else begin
          in_valid_i = 1'b0;
        end
      end
      out_ready_i = (accepted < STEADY_ITEMS) ? 1'b1 : (rand_below(4) != 0);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in_valid_i = 1'b0;
    // idle cycles so that a stray output is still caught
    repeat (4) @(posedge clk);
    $display("%0d words expanded and checked", received);
    $display("*** PASSED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // scoreboard, sampled at the falling edge where everything is stable
  //////////////////////////////////////////////////////////////////////

  initial begin : scoreboard
    rvc_pkg::expand_result_t expected;
    rvc_pkg::fetch_word_t    word;
    logic                    ready_model;
    accepted    = 0;
    received    = 0;
    in_taken    = 1'b0;
    model_valid = 1'b0;
    forever begin
      @(negedge clk);
      // also covers reset and the one-cycle latency
      assert (out_valid_o === model_valid) else begin
        $display("Error: out_valid_o = 0x%0h, expected 0x%0h", out_valid_o, model_valid);
        stop_with_failure();
      end
      // ready whenever the stage is empty or drains
      ready_model = !model_valid || out_ready_i;
      assert (reset_i || in_ready_o === ready_model) else begin
        $display("Error: in_ready_o = 0x%0h, expected 0x%0h", in_ready_o, ready_model);
        stop_with_failure();
      end
      in_taken = !reset_i && in_valid_i && ready_model;
      if (!reset_i && model_valid && out_ready_i) begin
        word     = in_flight.pop_front();
        expected = model_expand(word);
        assert (out_result_o === expected) else begin
          $display("Error: out_result_o = 0x%09h, expected 0x%09h, word 0x%08h",
                   out_result_o, expected, word);
          stop_with_failure();
        end
        received++;
      end
      if (in_taken) begin
        in_flight.push_back(in_word_i);
        accepted++;
      end
      // stage state after the coming rising edge
      if (reset_i) begin
        model_valid = 1'b0;
      end else begin
        model_valid = in_taken || (model_valid && !out_ready_i);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout, only %0d of %0d words came out", received, NUM_ITEMS);
    stop_with_failure();
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
rtl/rvc_pkg.sv
rtl/rvc_quadrant0_expander.sv
rtl/rvc_quadrant1_expander.sv
rtl/rvc_quadrant2_expander.sv
rtl/rvc_expander.sv
verification/rvc_expander_checker.sv
verification/rvc_expander_tb.sv

//--- Makefile
# Verilator build and run for the rv32c expander testbench

VERILATOR ?= verilator
TOP       ?= rvc_expander_tb
RTL_TOP   ?= rvc_expander
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# status comes from the search for the pass line, no log is kept
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
